// ==== axi_mem_sys.f ====
hw/mem_bus_pkg.sv
hw/sram_bank.sv
hw/axi_cpu_master.sv
hw/axi_sram_slave.sv
hw/axi_mem_sys.sv
sim/axi_mem_sys_tb.sv

// ==== hw/axi_cpu_master.sv ====
`timescale 1ns/1ps

module axi_cpu_master (
  input  logic                  clk,
  input  logic                  rstn,
  // Processor side
  input  logic                  access_request,
  input  logic                  write,
  input  mem_bus_pkg::strb_t    w_type,
  input  mem_bus_pkg::data_t    data_in,
  input  mem_bus_pkg::addr_t    addr,
  output mem_bus_pkg::data_t    data_out,
  output logic                  stall,
  // Write address channel
  output mem_bus_pkg::id_t      AWID,
  output mem_bus_pkg::addr_t    AWADDR,
  output mem_bus_pkg::len_t     AWLEN,
  output mem_bus_pkg::size_t    AWSIZE,
  output mem_bus_pkg::burst_t   AWBURST,
  output logic                  AWVALID,
  input  logic                  AWREADY,
  // Write data channel
  output mem_bus_pkg::data_t    WDATA,
  output mem_bus_pkg::strb_t    WSTRB,
  output logic                  WLAST,
  output logic                  WVALID,
  input  logic                  WREADY,
  // Write response channel
  input  mem_bus_pkg::id_t      BID,
  input  mem_bus_pkg::resp_t    BRESP,
  input  logic                  BVALID,
  output logic                  BREADY,
  // Read address channel
  output mem_bus_pkg::id_t      ARID,
  output mem_bus_pkg::addr_t    ARADDR,
  output mem_bus_pkg::len_t     ARLEN,
  output mem_bus_pkg::size_t    ARSIZE,
  output mem_bus_pkg::burst_t   ARBURST,
  output logic                  ARVALID,
  input  logic                  ARREADY,
  // Read data channel
  input  mem_bus_pkg::id_t      RID,
  input  mem_bus_pkg::data_t    RDATA,
  input  mem_bus_pkg::resp_t    RRESP,
  input  logic                  RLAST,
  input  logic                  RVALID,
  output logic                  RREADY
);

  import mem_bus_pkg::*;

  master_state_t state, next_state;
  addr_t araddr_r;
  addr_t awaddr_r;
  data_t wdata_r;
  strb_t wstrb_r;
  data_t rdata_r;
  logic  aw_hs;
  logic  w_hs;
  logic  b_hs;
  logic  ar_hs;
  logic  r_hs;

  assign aw_hs = AWVALID & AWREADY;
  assign w_hs  = WVALID & WREADY;
  assign b_hs  = BVALID & BREADY;
  assign ar_hs = ARVALID & ARREADY;
  assign r_hs  = RVALID & RREADY;

  // Read data passes straight through on the handshake, then is held
  assign data_out = r_hs ? RDATA : rdata_r;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rdata_r <= '0;
    end else if (r_hs) begin
      rdata_r <= RDATA;
    end
  end

  // Request payload captured on entry to the address states
  always_ff @(posedge clk) begin
    if (state != AR && next_state == AR) begin
      araddr_r <= addr;
    end
    if (state != AW && next_state == AW) begin
      awaddr_r <= addr;
      wdata_r  <= data_in;
      wstrb_r  <= w_type;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // The processor still holds its request in the completion cycle,
  // so a finished access returns to idle rather than reissuing it
  always_comb begin
    next_state = state;
    case (state)
      IDLE:    next_state = access_request ? (write ? AW : AR) : IDLE;
      AR:      next_state = ar_hs ? R : AR;
      R:       next_state = r_hs ? IDLE : R;
      AW:      next_state = aw_hs ? (w_hs ? B : W) : AW;
      W:       next_state = w_hs ? (b_hs ? IDLE : B) : W;
      B:       next_state = b_hs ? IDLE : B;
      default: next_state = IDLE;
    endcase
  end

  // Single-beat fields never change
  assign AWID    = CPU_ID;
  assign AWADDR  = awaddr_r;
  assign AWLEN   = '0;
  assign AWSIZE  = '0;
  assign AWBURST = BURST_INCR;
  assign WDATA   = wdata_r;
  assign WSTRB   = wstrb_r;
  assign WLAST   = 1'b1;
  assign ARID    = CPU_ID;
  assign ARADDR  = araddr_r;
  assign ARLEN   = '0;
  assign ARSIZE  = '0;
  assign ARBURST = BURST_INCR;

  always_comb begin
    AWVALID = 1'b0;
    WVALID  = 1'b0;
    BREADY  = 1'b0;
    ARVALID = 1'b0;
    RREADY  = 1'b0;
    stall   = 1'b0;
    case (state)
      AR: begin
        ARVALID = 1'b1;
        stall   = 1'b1;
      end
      R: begin
        RREADY = 1'b1;
        stall  = ~RLAST;
      end
      AW: begin
        AWVALID = 1'b1;
        // Data may follow in the same cycle if the slave allows it
        WVALID  = aw_hs;
        stall   = 1'b1;
      end
      W: begin
        WVALID = 1'b1;
        BREADY = 1'b1;
        stall  = 1'b1;
      end
      B: begin
        BREADY = 1'b1;
        stall  = ~BVALID;
      end
      default: begin
        stall = 1'b0;
      end
    endcase
  end

endmodule

// ==== hw/axi_mem_sys.sv ====
`timescale 1ns/1ps

module axi_mem_sys (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  access_request,
  input  logic                  write,
  input  mem_bus_pkg::strb_t    w_type,
  input  mem_bus_pkg::data_t    data_in,
  input  mem_bus_pkg::addr_t    addr,
  input  mem_bus_pkg::wait_t    mem_wait,
  output mem_bus_pkg::data_t    data_out,
  output logic                  stall
);

  import mem_bus_pkg::*;

  // AW channel
  id_t    AWID;
  addr_t  AWADDR;
  len_t   AWLEN;
  size_t  AWSIZE;
  burst_t AWBURST;
  logic   AWVALID;
  logic   AWREADY;

  // W channel
  data_t  WDATA;
  strb_t  WSTRB;
  logic   WLAST;
  logic   WVALID;
  logic   WREADY;

  // B channel
  id_t    BID;
  resp_t  BRESP;
  logic   BVALID;
  logic   BREADY;

  // AR channel
  id_t    ARID;
  addr_t  ARADDR;
  len_t   ARLEN;
  size_t  ARSIZE;
  burst_t ARBURST;
  logic   ARVALID;
  logic   ARREADY;

  // R channel
  id_t    RID;
  data_t  RDATA;
  resp_t  RRESP;
  logic   RLAST;
  logic   RVALID;
  logic   RREADY;

  // Slave to SRAM
  logic   mem_en;
  strb_t  mem_we;
  index_t mem_index;
  data_t  mem_wdata;
  data_t  mem_rdata;

  // Port and wire names match, so connect by name
  axi_cpu_master axi_cpu_master_inst (.*);

  axi_sram_slave axi_sram_slave_inst (.*);

  sram_bank sram_bank_inst (.*);

endmodule

// ==== hw/axi_sram_slave.sv ====
`timescale 1ns/1ps

module axi_sram_slave (
  input  logic                  clk,
  input  logic                  rstn,
  input  mem_bus_pkg::wait_t    mem_wait,
  // Write address channel
  input  mem_bus_pkg::id_t      AWID,
  input  mem_bus_pkg::addr_t    AWADDR,
  input  mem_bus_pkg::len_t     AWLEN,
  input  mem_bus_pkg::size_t    AWSIZE,
  input  mem_bus_pkg::burst_t   AWBURST,
  input  logic                  AWVALID,
  output logic                  AWREADY,
  // Write data channel
  input  mem_bus_pkg::data_t    WDATA,
  input  mem_bus_pkg::strb_t    WSTRB,
  input  logic                  WLAST,
  input  logic                  WVALID,
  output logic                  WREADY,
  // Write response channel
  output mem_bus_pkg::id_t      BID,
  output mem_bus_pkg::resp_t    BRESP,
  output logic                  BVALID,
  input  logic                  BREADY,
  // Read address channel
  input  mem_bus_pkg::id_t      ARID,
  input  mem_bus_pkg::addr_t    ARADDR,
  input  mem_bus_pkg::len_t     ARLEN,
  input  mem_bus_pkg::size_t    ARSIZE,
  input  mem_bus_pkg::burst_t   ARBURST,
  input  logic                  ARVALID,
  output logic                  ARREADY,
  // Read data channel
  output mem_bus_pkg::id_t      RID,
  output mem_bus_pkg::data_t    RDATA,
  output mem_bus_pkg::resp_t    RRESP,
  output logic                  RLAST,
  output logic                  RVALID,
  input  logic                  RREADY,
  // SRAM bank
  output logic                  mem_en,
  output mem_bus_pkg::strb_t    mem_we,
  output mem_bus_pkg::index_t   mem_index,
  output mem_bus_pkg::data_t    mem_wdata,
  input  mem_bus_pkg::data_t    mem_rdata
);

  import mem_bus_pkg::*;

  slave_state_t state, next_state;
  id_t    id_r;
  index_t index_r;
  wait_t  wait_cnt;
  logic   aw_hs;
  logic   w_hs;
  logic   ar_hs;
  logic   wait_done;

  // Writes win when both address channels are valid
  assign AWREADY = (state == S_IDLE);
  assign ARREADY = (state == S_IDLE) & ~AWVALID;
  assign WREADY  = (state == S_WR_DATA);

  assign aw_hs     = AWVALID & AWREADY;
  assign w_hs      = WVALID & WREADY;
  assign ar_hs     = ARVALID & ARREADY;
  assign wait_done = (wait_cnt == '0);

  // Only the word index selects a row, upper address bits alias
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      id_r    <= AWID;
      index_r <= AWADDR[INDEX_BITS+1:2];
    end else if (ar_hs) begin
      id_r    <= ARID;
      index_r <= ARADDR[INDEX_BITS+1:2];
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wait_cnt <= '0;
    end else if (aw_hs || ar_hs) begin
      wait_cnt <= mem_wait;
    end else if (!wait_done && (state == S_RD_MEM || state == S_RD_WAIT ||
                                state == S_WR_WAIT)) begin
      wait_cnt <= wait_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= S_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      S_IDLE: begin
        if (aw_hs) next_state = S_WR_DATA;
        else if (ar_hs) next_state = S_RD_MEM;
      end
      // Read wait may be skipped entirely
      S_RD_MEM:  next_state = wait_done ? S_RD_RESP : S_RD_WAIT;
      S_RD_WAIT: next_state = wait_done ? S_RD_RESP : S_RD_WAIT;
      S_RD_RESP: next_state = RREADY ? S_IDLE : S_RD_RESP;
      // Write always spends one cycle here after the SRAM write
      S_WR_DATA: next_state = w_hs ? S_WR_WAIT : S_WR_DATA;
      S_WR_WAIT: next_state = wait_done ? S_WR_RESP : S_WR_WAIT;
      S_WR_RESP: next_state = BREADY ? S_IDLE : S_WR_RESP;
      default:   next_state = S_IDLE;
    endcase
  end

  assign mem_en    = (state == S_RD_MEM) | w_hs;
  assign mem_we    = w_hs ? WSTRB : '0;
  assign mem_index = index_r;
  assign mem_wdata = WDATA;

  // Bank output register holds the word through the wait cycles
  assign RVALID = (state == S_RD_RESP);
  assign RLAST  = RVALID;
  assign RDATA  = mem_rdata;
  assign RID    = id_r;
  assign RRESP  = RESP_OKAY;

  assign BVALID = (state == S_WR_RESP);
  assign BID    = id_r;
  assign BRESP  = RESP_OKAY;

endmodule

// ==== hw/mem_bus_pkg.sv ====
package mem_bus_pkg;

  // Bus widths
  localparam int ADDR_BITS  = 32;
  localparam int DATA_BITS  = 32;
  localparam int STRB_BITS  = DATA_BITS / 8;
  localparam int ID_BITS    = 4;
  localparam int LEN_BITS   = 8;
  localparam int SIZE_BITS  = 3;
  localparam int BURST_BITS = 2;
  localparam int RESP_BITS  = 2;

  // SRAM geometry, word index sits at address bits 9:2
  localparam int MEM_WORDS  = 256;
  localparam int INDEX_BITS = $clog2(MEM_WORDS);
  localparam int WAIT_BITS  = 2;

  typedef logic [ADDR_BITS-1:0]  addr_t;
  typedef logic [DATA_BITS-1:0]  data_t;
  typedef logic [STRB_BITS-1:0]  strb_t;
  typedef logic [ID_BITS-1:0]    id_t;
  typedef logic [LEN_BITS-1:0]   len_t;
  typedef logic [SIZE_BITS-1:0]  size_t;
  typedef logic [BURST_BITS-1:0] burst_t;
  typedef logic [RESP_BITS-1:0]  resp_t;
  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [WAIT_BITS-1:0]  wait_t;

  // AXI field codes
  localparam id_t    CPU_ID     = ID_BITS'(1);
  localparam burst_t BURST_INCR = 2'b01;
  localparam resp_t  RESP_OKAY  = 2'b00;

  typedef enum logic [2:0] {
    IDLE,
    AR,
    R,
    AW,
    W,
    B
  } master_state_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_RD_MEM,
    S_RD_WAIT,
    S_RD_RESP,
    S_WR_DATA,
    S_WR_WAIT,
    S_WR_RESP
  } slave_state_t;

endpackage

// ==== hw/sram_bank.sv ====
`timescale 1ns/1ps

module sram_bank (
  input  logic                  clk,
  input  logic                  mem_en,
  input  mem_bus_pkg::strb_t    mem_we,
  input  mem_bus_pkg::index_t   mem_index,
  input  mem_bus_pkg::data_t    mem_wdata,
  output mem_bus_pkg::data_t    mem_rdata
);

  import mem_bus_pkg::*;

  data_t mem [MEM_WORDS];

  // Write byte lanes when any strobe is set, otherwise read
  always_ff @(posedge clk) begin
    if (mem_en) begin
      if (mem_we != '0) begin
        for (int lane = 0; lane < STRB_BITS; lane++) begin
          if (mem_we[lane]) begin
            mem[mem_index][lane*8 +: 8] <= mem_wdata[lane*8 +: 8];
          end
        end
      end else begin
        mem_rdata <= mem[mem_index];
      end
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the AXI memory subsystem testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=axi_mem_sys_sim
LOG=sim.log

verilator --binary --timing -Wno-fatal \
  -f axi_mem_sys.f \
  --top-module axi_mem_sys_tb \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi
exit 0

// ==== sim/axi_mem_sys_tb.sv ====
`timescale 1ns/1ps

module axi_mem_sys_tb;

  import mem_bus_pkg::*;

  localparam int TIMEOUT_CYCLES = 50;

  typedef struct packed {
    logic  wr;
    addr_t addr;
    strb_t strb;
    data_t data;
    logic  rnd;
    wait_t wt;
  } row_t;

  logic  clk = 1'b0;
  logic  rstn;
  logic  access_request;
  logic  write;
  strb_t w_type;
  data_t data_in;
  addr_t addr;
  wait_t mem_wait;
  data_t data_out;
  logic  stall;

  row_t        table_q[$];
  data_t       ref_mem [256];
  data_t       last_read;
  logic [15:0] lfsr_state;
  int          error_count;
  int          tests_passed;
  int          tests_failed;
  logic        timed_out;

  axi_mem_sys axi_mem_sys_inst (
    .clk            (clk),
    .rstn           (rstn),
    .access_request (access_request),
    .write          (write),
    .w_type         (w_type),
    .data_in        (data_in),
    .addr           (addr),
    .mem_wait       (mem_wait),
    .data_out       (data_out),
    .stall          (stall)
  );

  always #20 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic random_word(output data_t w);
    for (int i = 0; i < DATA_BITS; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w[i] = lfsr_state[0];
    end
  endtask

  task automatic add_row(input logic wr, input addr_t a, input strb_t s, input data_t d,
                         input logic rnd, input wait_t wt);
    row_t row;
    row = '{wr: wr, addr: a, strb: s, data: d, rnd: rnd, wt: wt};
    table_q.push_back(row);
  endtask

  // Word index is address bits 9:2 and higher bits alias
  task automatic merge_write(input addr_t a, input strb_t s, input data_t d);
    for (int lane = 0; lane < 4; lane++) begin
      if (s[lane]) begin
        ref_mem[a[9:2]][lane*8 +: 8] = d[lane*8 +: 8];
      end
    end
  endtask

  task automatic check_data(input data_t got, input data_t expected, input string msg);
    if (got !== expected) begin
      $display("mismatch at %0t: %s, got %h expected %h", $time, msg, got, expected);
      error_count++;
    end
  endtask

  task automatic check_flag(input logic got, input logic expected, input string msg);
    if (got !== expected) begin
      $display("mismatch at %0t: %s, got %b expected %b", $time, msg, got, expected);
      error_count++;
    end
  endtask

  task automatic run_row(input int idx);
    row_t  row;
    data_t wdata;
    int    cycles;
    logic  done;
    row = table_q[idx];
    wdata = row.data;
    if (row.rnd) begin
      random_word(wdata);
    end
    @(posedge clk);
    access_request <= 1'b1;
    write          <= row.wr;
    w_type         <= row.strb;
    data_in        <= wdata;
    addr           <= row.addr;
    mem_wait       <= row.wt;
    // Request cycle itself never completes
    @(negedge clk);
    cycles = 0;
    done = 1'b0;
    while (!done && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
      done = (stall === 1'b0);
    end
    if (!done) begin
      $display("row %0d: stall stayed high for %0d cycles, access never completed",
               idx, TIMEOUT_CYCLES);
      error_count++;
      timed_out = 1'b1;
    end else if (row.wr) begin
      merge_write(row.addr, row.strb, wdata);
      check_data(data_out, last_read, "data_out during write completion");
    end else begin
      check_data(data_out, ref_mem[row.addr[9:2]], "read data");
      last_read = ref_mem[row.addr[9:2]];
    end
    @(posedge clk);
    access_request <= 1'b0;
    @(negedge clk);
    check_flag(stall, 1'b0, "stall while idle");
    check_data(data_out, last_read, "data_out held while idle");
  endtask

  initial begin
    int errs_before;
    rstn           = 1'b0;
    access_request = 1'b0;
    write          = 1'b0;
    w_type         = '0;
    data_in        = '0;
    addr           = '0;
    mem_wait       = '0;
    lfsr_state     = 16'd69;
    last_read      = '0;
    error_count    = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    timed_out      = 1'b0;

    // Full-strobe write then read back
    add_row(1, 32'h0000_0000, 4'hF, '0, 1, 0);
    add_row(0, 32'h0000_0000, 4'h0, '0, 0, 0);
    add_row(1, 32'h0000_0004, 4'hF, '0, 1, 1);
    add_row(0, 32'h0000_0004, 4'h0, '0, 0, 1);
    add_row(1, 32'h0000_03FC, 4'hF, '0, 1, 2);
    add_row(0, 32'h0000_03FC, 4'h0, '0, 0, 2);
    add_row(1, 32'h0000_0120, 4'hF, '0, 1, 3);
    add_row(0, 32'h0000_0120, 4'h0, '0, 0, 3);
    // Byte and half-word merges
    add_row(1, 32'h0000_0040, 4'hF, 32'h1122_3344, 0, 0);
    add_row(1, 32'h0000_0040, 4'b0001, 32'hAAAA_AAAA, 0, 0);
    add_row(0, 32'h0000_0040, 4'h0, '0, 0, 0);
    add_row(1, 32'h0000_0040, 4'b1100, 32'hBBBB_CCCC, 0, 1);
    add_row(0, 32'h0000_0040, 4'h0, '0, 0, 0);
    add_row(1, 32'h0000_0040, 4'b0010, '0, 1, 2);
    add_row(0, 32'h0000_0040, 4'h0, '0, 0, 3);
    // Mixed traffic with varying waits
    add_row(1, 32'h0000_0080, 4'hF, '0, 1, 3);
    add_row(0, 32'h0000_0080, 4'h0, '0, 0, 2);
    add_row(1, 32'h0000_0080, 4'b0110, '0, 1, 1);
    add_row(0, 32'h0000_0080, 4'h0, '0, 0, 3);
    add_row(0, 32'h0000_0004, 4'h0, '0, 0, 0);
    add_row(1, 32'h0000_0084, 4'hF, '0, 1, 2);
    add_row(0, 32'h0000_03FC, 4'h0, '0, 0, 1);
    // Aliasing above bit 9
    add_row(1, 32'h1000_0200, 4'hF, '0, 1, 0);
    add_row(0, 32'hFFFF_FE00, 4'h0, '0, 0, 0);
    add_row(1, 32'hABC0_0014, 4'hF, '0, 1, 1);
    add_row(0, 32'h0000_0014, 4'h0, '0, 0, 2);

    repeat (2) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    check_flag(stall, 1'b0, "stall after reset");
    check_data(data_out, '0, "data_out after reset");
    if (error_count == 0) begin
      tests_passed++;
      $display("test reset: ok");
    end else begin
      tests_failed++;
      $display("test reset: FAIL");
    end

    for (int i = 0; i < table_q.size() && !timed_out; i++) begin
      errs_before = error_count;
      run_row(i);
      if (error_count == errs_before) begin
        tests_passed++;
      end else begin
        tests_failed++;
      end
      $display("test row %0d (%s addr %h wait %0d): %s", i,
               table_q[i].wr ? "write" : "read", table_q[i].addr, table_q[i].wt,
               error_count == errs_before ? "ok" : "FAIL");
    end

    $display("%0d tests, %0d ok, %0d failing, %0d errors",
             tests_passed + tests_failed, tests_passed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
